/* cla_pkg.sv */
`default_nettype none

package cla_pkg;

    // Wishbone data path
    localparam int BUS_WIDTH = 32;
    typedef logic [BUS_WIDTH-1:0] bus_word_t;

    // Word index taken from byte address bits 4..2
    localparam int ADR_LSB = 2;
    typedef logic [2:0] reg_addr_t;

    localparam reg_addr_t REG_A      = 3'd0;
    localparam reg_addr_t REG_B      = 3'd1;
    localparam reg_addr_t REG_CTRL   = 3'd2;
    localparam reg_addr_t REG_RESULT = 3'd3;
    localparam reg_addr_t REG_STATUS = 3'd4;

    // Control word
    typedef logic [2:0] ctrl_t;
    localparam int CTRL_CIN = 0;
    localparam int CTRL_SUB = 1;
    localparam int CTRL_ACC = 2;

    // Status word
    typedef logic [2:0] status_t;
    localparam int STAT_CARRY  = 0;
    localparam int STAT_OVF    = 1;
    localparam int STAT_STICKY = 2;

    // Width of one lookahead block
    localparam int GROUP_BITS = 4;

endpackage

`default_nettype wire

/* cla_block4.sv */
`timescale 1ns/10ps
`default_nettype none

module cla_block4 (
    input  wire  [3:0] a,
    input  wire  [3:0] b,
    input  wire        cin,
    output logic [3:0] s,
    output logic       gg,
    output logic       pg
);

    logic [3:0] g;
    logic [3:0] p;
    logic [3:0] c;

    // Bit generate and propagate
    assign g = a & b;
    assign p = a ^ b;

    // Internal carries, all from cin directly
    assign c[0] = cin;
    assign c[1] = g[0] | (p[0] & cin);
    assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
    assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                | (p[2] & p[1] & p[0] & cin);

    assign s = p ^ c;

    // Group terms for the outer lookahead level
    assign pg = &p;
    assign gg = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
              | (p[3] & p[2] & p[1] & g[0]);

endmodule

`default_nettype wire

/* cla_adder.sv */
`timescale 1ns/10ps
`default_nettype none

module cla_adder #(
    parameter int OP_WIDTH = 32
) (
    input  wire  [OP_WIDTH-1:0] a,
    input  wire  [OP_WIDTH-1:0] b,
    input  wire                 cin,
    output logic [OP_WIDTH-1:0] s,
    output logic                cout,
    output logic                overflow
);

    import cla_pkg::*;

    localparam int NGROUPS = OP_WIDTH / GROUP_BITS;

    logic [NGROUPS-1:0] gg;
    logic [NGROUPS-1:0] pg;
    logic [NGROUPS:0]   gc;

    // Carry into group k as a flat sum of products over groups 0..k-1
    function automatic logic group_carry(
        input logic [NGROUPS-1:0] g,
        input logic [NGROUPS-1:0] p,
        input logic               c0,
        input int                 k
    );
        logic carry;
        logic chain;
        carry = 1'b0;
        for (int j = 0; j < k; j++) begin
            chain = g[j];
            for (int m = j + 1; m < k; m++) begin
                chain = chain & p[m];
            end
            carry = carry | chain;
        end
        // Input carry passed through every lower group
        chain = c0;
        for (int m = 0; m < k; m++) begin
            chain = chain & p[m];
        end
        return carry | chain;
    endfunction

    assign gc[0] = cin;

    for (genvar k = 0; k < NGROUPS; k++) begin : g_group
        cla_block4 cla_block4_i (
            .a   (a[k*GROUP_BITS +: GROUP_BITS]),
            .b   (b[k*GROUP_BITS +: GROUP_BITS]),
            .cin (gc[k]),
            .s   (s[k*GROUP_BITS +: GROUP_BITS]),
            .gg  (gg[k]),
            .pg  (pg[k])
        );

        assign gc[k+1] = group_carry(gg, pg, cin, k + 1);
    end

    assign cout = gc[NGROUPS];

    // Same operand signs but a different result sign
    assign overflow = (a[OP_WIDTH-1] == b[OP_WIDTH-1])
                   && (s[OP_WIDTH-1] != a[OP_WIDTH-1]);

endmodule

`default_nettype wire

/* wb_cmd_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_cmd_decode #(
    parameter int OP_WIDTH = 32
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       wb_cyc,
    input  wire                       wb_stb,
    input  wire                       wb_we,
    input  wire cla_pkg::bus_word_t   wb_adr,
    input  wire cla_pkg::bus_word_t   wb_dat_w,
    output logic                      wb_ack,
    output logic [OP_WIDTH-1:0]       op_a,
    output logic [OP_WIDTH-1:0]       op_b,
    output cla_pkg::ctrl_t            ctrl,
    output logic                      start,
    output logic                      sticky_clr,
    output cla_pkg::reg_addr_t        rd_idx
);

    import cla_pkg::*;

    logic      req;
    logic      wr;
    reg_addr_t idx;
    logic      ctrl_wr_q;

    // New request only while no ack is out
    assign req = wb_cyc && wb_stb && !wb_ack;
    assign wr  = req && wb_we;
    assign idx = wb_adr[ADR_LSB +: $bits(reg_addr_t)];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack     <= 1'b0;
            rd_idx     <= '0;
            op_a       <= '0;
            op_b       <= '0;
            ctrl       <= '0;
            ctrl_wr_q  <= 1'b0;
            start      <= 1'b0;
            sticky_clr <= 1'b0;
        end else begin
            wb_ack     <= req;
            ctrl_wr_q  <= wr && (idx == REG_CTRL);
            // Start follows the control write ack by one cycle
            start      <= ctrl_wr_q;
            sticky_clr <= wr && (idx == REG_STATUS) && wb_dat_w[STAT_STICKY];

            if (req) begin
                rd_idx <= idx;
            end

            if (wr) begin
                case (idx)
                    REG_A:    op_a <= wb_dat_w[OP_WIDTH-1:0];
                    REG_B:    op_b <= wb_dat_w[OP_WIDTH-1:0];
                    REG_CTRL: ctrl <= wb_dat_w[$bits(ctrl_t)-1:0];
                    // Result is read-only, status only clears sticky
                    default:  ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* add_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module add_unit #(
    parameter int OP_WIDTH = 32
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [OP_WIDTH-1:0]   op_a,
    input  wire [OP_WIDTH-1:0]   op_b,
    input  wire cla_pkg::ctrl_t  ctrl,
    input  wire                  start,
    input  wire [OP_WIDTH-1:0]   prev_result,
    output logic [OP_WIDTH-1:0]  sum,
    output logic                 carry,
    output logic                 overflow,
    output logic                 done
);

    import cla_pkg::*;

    logic [OP_WIDTH-1:0] a_in;
    logic [OP_WIDTH-1:0] b_in;
    logic                cin_eff;
    logic [OP_WIDTH-1:0] add_s;
    logic                add_cout;
    logic                add_ovf;

    // Accumulate chains on the stored result
    assign a_in = ctrl[CTRL_ACC] ? prev_result : op_a;

    // Subtract as A + ~B + 1, carry-in set turns it into A - B - 1
    assign b_in    = ctrl[CTRL_SUB] ? ~op_b : op_b;
    assign cin_eff = ctrl[CTRL_CIN] ^ ctrl[CTRL_SUB];

    cla_adder #(
        .OP_WIDTH (OP_WIDTH)
    ) cla_adder_i (
        .a        (a_in),
        .b        (b_in),
        .cin      (cin_eff),
        .s        (add_s),
        .cout     (add_cout),
        .overflow (add_ovf)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum      <= '0;
            carry    <= 1'b0;
            overflow <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= start;
            if (start) begin
                sum      <= add_s;
                carry    <= add_cout;
                overflow <= add_ovf;
            end
        end
    end

endmodule

`default_nettype wire

/* result_store.sv */
`timescale 1ns/10ps
`default_nettype none

module result_store #(
    parameter int OP_WIDTH = 32
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire [OP_WIDTH-1:0]       sum,
    input  wire                      carry,
    input  wire                      overflow,
    input  wire                      done,
    input  wire                      sticky_clr,
    input  wire cla_pkg::reg_addr_t  rd_idx,
    input  wire [OP_WIDTH-1:0]       op_a,
    input  wire [OP_WIDTH-1:0]       op_b,
    input  wire cla_pkg::ctrl_t      ctrl,
    output logic [OP_WIDTH-1:0]      prev_result,
    output cla_pkg::bus_word_t       wb_dat_r
);

    import cla_pkg::*;

    logic [OP_WIDTH-1:0] result_q;
    logic                carry_q;
    logic                ovf_q;
    logic                sticky_q;
    status_t             status;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_q <= '0;
            carry_q  <= 1'b0;
            ovf_q    <= 1'b0;
            sticky_q <= 1'b0;
        end else begin
            if (done) begin
                result_q <= sum;
                carry_q  <= carry;
                ovf_q    <= overflow;
            end
            // A new overflow beats a clear in the same cycle
            if (done && overflow) begin
                sticky_q <= 1'b1;
            end else if (sticky_clr) begin
                sticky_q <= 1'b0;
            end
        end
    end

    assign prev_result = result_q;

    always_comb begin
        status              = '0;
        status[STAT_CARRY]  = carry_q;
        status[STAT_OVF]    = ovf_q;
        status[STAT_STICKY] = sticky_q;
    end

    // Narrow registers read back zero-extended
    always_comb begin
        case (rd_idx)
            REG_A:      wb_dat_r = BUS_WIDTH'(op_a);
            REG_B:      wb_dat_r = BUS_WIDTH'(op_b);
            REG_CTRL:   wb_dat_r = BUS_WIDTH'(ctrl);
            REG_RESULT: wb_dat_r = BUS_WIDTH'(result_q);
            REG_STATUS: wb_dat_r = BUS_WIDTH'(status);
            default:    wb_dat_r = '0;
        endcase
    end

endmodule

`default_nettype wire

/* cla_wb_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cla_wb_top #(
    parameter int OP_WIDTH = 32
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      wb_cyc,
    input  wire                      wb_stb,
    input  wire                      wb_we,
    input  wire cla_pkg::bus_word_t  wb_adr,
    input  wire cla_pkg::bus_word_t  wb_dat_w,
    output cla_pkg::bus_word_t       wb_dat_r,
    output logic                     wb_ack
);

    import cla_pkg::*;

    logic [OP_WIDTH-1:0] op_a;
    logic [OP_WIDTH-1:0] op_b;
    ctrl_t               ctrl;
    logic                start;
    logic                sticky_clr;
    reg_addr_t           rd_idx;
    logic [OP_WIDTH-1:0] sum;
    logic                carry;
    logic                overflow;
    logic                done;
    logic [OP_WIDTH-1:0] prev_result;

    wb_cmd_decode #(
        .OP_WIDTH (OP_WIDTH)
    ) wb_cmd_decode_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_ack     (wb_ack),
        .op_a       (op_a),
        .op_b       (op_b),
        .ctrl       (ctrl),
        .start      (start),
        .sticky_clr (sticky_clr),
        .rd_idx     (rd_idx)
    );

    add_unit #(
        .OP_WIDTH (OP_WIDTH)
    ) add_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_a        (op_a),
        .op_b        (op_b),
        .ctrl        (ctrl),
        .start       (start),
        .prev_result (prev_result),
        .sum         (sum),
        .carry       (carry),
        .overflow    (overflow),
        .done        (done)
    );

    result_store #(
        .OP_WIDTH (OP_WIDTH)
    ) result_store_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .sum         (sum),
        .carry       (carry),
        .overflow    (overflow),
        .done        (done),
        .sticky_clr  (sticky_clr),
        .rd_idx      (rd_idx),
        .op_a        (op_a),
        .op_b        (op_b),
        .ctrl        (ctrl),
        .prev_result (prev_result),
        .wb_dat_r    (wb_dat_r)
    );

endmodule

`default_nettype wire

/* tb_cla_wb_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cla_wb_top;

    import cla_pkg::*;

    localparam int        CLK_PERIOD      = 40;
    localparam int        DRV             = 2;
    localparam int        RESET_CYCLES    = 16;
    localparam int        ACK_LIMIT       = 16;
    localparam int        CYCLES_PER_OP   = 40;
    localparam int        WATCHDOG_MARGIN = 100;
    localparam string     PATTERN_FILE    = "cla_patterns.txt";
    localparam bus_word_t CMD_STATUS_WR   = 32'd8;
    localparam bus_word_t CMD_RESULT_WR   = 32'd9;

    logic      clk;
    logic      rst_n;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    bus_word_t wb_adr;
    bus_word_t wb_dat_w;
    bus_word_t wb_dat_r;
    logic      wb_ack;

    bus_word_t pat_ctrl[$];
    bus_word_t pat_a[$];
    bus_word_t pat_b[$];
    bus_word_t pat_res[$];
    status_t   pat_stat[$];

    int   n_ops;
    logic loaded;
    int   result_errors;
    int   status_errors;
    int   other_errors;

    cla_wb_top #(
        .OP_WIDTH (32)
    ) cla_wb_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRV;
        end
    endtask

    task automatic idle_gap();
        int n;
        n = $urandom % 4;
        wait_cycles(n);
    endtask

    // One classic cycle, held until the slave acks or the limit runs out
    task automatic bus_cycle(input reg_addr_t idx, input logic we,
                             input bus_word_t wdata, output bus_word_t rdata);
        int   waited;
        logic acked;
        waited   = 0;
        acked    = 1'b0;
        rdata    = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = bus_word_t'(idx) << ADR_LSB;
        wb_dat_w = wdata;
        while (!acked && waited < ACK_LIMIT) begin
            @(posedge clk);
            #DRV;
            waited++;
            if (wb_ack) begin
                acked = 1'b1;
                rdata = wb_dat_r;
            end
        end
        if (!acked) begin
            $display("Bus error at %0t: the ack for a %s of register %0d never came",
                     $time, we ? "write" : "read", idx);
            other_errors++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input reg_addr_t idx, input bus_word_t data);
        bus_word_t ignored;
        bus_cycle(idx, 1'b1, data, ignored);
    endtask

    task automatic bus_read(input reg_addr_t idx, output bus_word_t data);
        bus_cycle(idx, 1'b0, '0, data);
    endtask

    task automatic check_result(input string name, input bus_word_t got,
                                input bus_word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            result_errors++;
        end
    endtask

    task automatic check_status(input string name, input status_t got,
                                input status_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            status_errors++;
        end
    endtask

    task automatic load_patterns();
        int        fd;
        int        fields;
        string     line;
        bus_word_t c;
        bus_word_t a;
        bus_word_t b;
        bus_word_t r;
        bus_word_t s;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file %s", PATTERN_FILE);
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                fields = $fgets(line, fd);
                // Skip comments and blank lines
                if (fields > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h", c, a, b, r, s);
                    if (fields == 5) begin
                        pat_ctrl.push_back(c);
                        pat_a.push_back(a);
                        pat_b.push_back(b);
                        pat_res.push_back(r);
                        pat_stat.push_back(status_t'(s));
                    end else begin
                        $display("Malformed pattern line: %s", line);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
        end
        n_ops = pat_ctrl.size();
        if (n_ops == 0) begin
            $display("No patterns were loaded");
            other_errors++;
        end
    endtask

    task automatic run_line(input int i);
        bus_word_t rdata;
        case (pat_ctrl[i])
            CMD_STATUS_WR: bus_write(REG_STATUS, pat_a[i]);
            CMD_RESULT_WR: bus_write(REG_RESULT, pat_a[i]);
            default: begin
                bus_write(REG_A, pat_a[i]);
                idle_gap();
                bus_write(REG_B, pat_b[i]);
                idle_gap();
                bus_write(REG_CTRL, pat_ctrl[i]);
            end
        endcase
        wait_cycles(3);
        bus_read(REG_RESULT, rdata);
        check_result($sformatf("result[%0d]", i), rdata, pat_res[i]);
        idle_gap();
        bus_read(REG_STATUS, rdata);
        check_status($sformatf("status[%0d]", i), status_t'(rdata), pat_stat[i]);
        // Register readback only after a real operation
        if (pat_ctrl[i] < CMD_STATUS_WR) begin
            idle_gap();
            bus_read(REG_A, rdata);
            check_result($sformatf("reg_a[%0d]", i), rdata, pat_a[i]);
            idle_gap();
            bus_read(REG_B, rdata);
            check_result($sformatf("reg_b[%0d]", i), rdata, pat_b[i]);
            idle_gap();
            bus_read(REG_CTRL, rdata);
            check_result($sformatf("reg_ctrl[%0d]", i), rdata, pat_ctrl[i]);
        end
        idle_gap();
    endtask

    task automatic finish_run();
        $display("Errors: result %0d, status %0d, other %0d",
                 result_errors, status_errors, other_errors);
        if (result_errors + status_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin
        rst_n         = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        n_ops         = 0;
        loaded        = 1'b0;
        result_errors = 0;
        status_errors = 0;
        other_errors  = 0;
        void'($urandom(32'h4dc2));
        load_patterns();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRV;
        rst_n = 1'b1;
        wait_cycles(1);
        for (int i = 0; i < n_ops; i++) begin
            run_line(i);
        end
        finish_run();
    end

    initial begin : watchdog
        wait (loaded);
        repeat (n_ops * CYCLES_PER_OP + WATCHDOG_MARGIN) @(posedge clk);
        $display("Watchdog expired after %0d clock periods, the run did not finish",
                 n_ops * CYCLES_PER_OP + WATCHDOG_MARGIN);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* cla_wb_top.f */
cla_pkg.sv
cla_block4.sv
cla_adder.sv
wb_cmd_decode.sv
add_unit.sv
result_store.sv
cla_wb_top.sv
tb_cla_wb_top.sv

/* Makefile */
SIM  := obj_dir/Vtb_cla_wb_top
SRCS := $(shell cat cla_wb_top.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): cla_wb_top.f $(SRCS)
	verilator --binary --timescale 1ns/10ps -j 0 --top-module tb_cla_wb_top \
		-f cla_wb_top.f --Mdir obj_dir -o Vtb_cla_wb_top

# Pass only when the testbench printed its pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '=== PASS ==='

clean:
	rm -rf obj_dir

/* cla_patterns.txt */
# ctrl a b result status, all hex; ctrl 0-7 = cin/sub/acc operation
# ctrl 8 = status write of a, ctrl 9 = write of a to the result register
0 00000001 00000002 00000003 0
1 00000001 00000002 00000004 0
0 0FFFFFFF 00000001 10000000 0
0 FFFFFFFF 00000001 00000000 1
1 FFFFFFFF 00000000 00000000 1
0 00000FFF 00000001 00001000 0
0 0000FFFF 00000001 00010000 0
1 000FFFFF 00000000 00100000 0
0 00FFFFFF 00000001 01000000 0
0 FFFFFFFF FFFFFFFF FFFFFFFE 1
0 7FFFFFFF 00000001 80000000 6
0 12345678 11111111 23456789 4
0 80000000 80000000 00000000 7
8 00000004 00000000 00000000 3
0 00000005 00000003 00000008 0
2 0000000A 00000003 00000007 1
3 0000000A 00000003 00000006 1
2 00000003 0000000A FFFFFFF9 0
2 80000000 00000001 7FFFFFFF 7
2 00000000 00000000 00000000 5
3 00000000 00000000 FFFFFFFF 4
8 00000004 00000000 FFFFFFFF 0
2 7FFFFFFF FFFFFFFF 80000000 6
8 00000000 00000000 80000000 6
8 00000004 00000000 80000000 2
4 DEADBEEF 00000001 80000001 0
4 00000000 00000010 80000011 0
6 00000000 00000011 80000000 1
6 00000000 00000001 7FFFFFFF 7
5 00000000 00000000 80000000 6
8 00000004 00000000 80000000 2
0 00000100 00000200 00000300 0
4 00000000 00000300 00000600 0
9 55555555 00000000 00000600 0
7 00000000 00000001 000005FE 1
0 89ABCDEF 76543210 FFFFFFFF 0
1 89ABCDEF 76543210 00000000 1
9 AAAAAAAA 00000000 00000000 1
